// File: hw/decim_settings.svh
// Width and limit macros for the IQ decimator, included by the packages and every RTL module
`ifndef DECIM_SETTINGS_SVH
`define DECIM_SETTINGS_SVH

// ----------------------------------------------------------------------
// Channel layout
// ----------------------------------------------------------------------
`define DECIM_CH_NUM 2
`define DECIM_SAMPLE_W 16

// ----------------------------------------------------------------------
// Accumulation and rounding
// ----------------------------------------------------------------------
// Enough headroom for 16 full-scale samples
`define DECIM_GUARD_W 4
`define DECIM_ACC_W (`DECIM_SAMPLE_W + `DECIM_GUARD_W)
`define DECIM_ERR_W (`DECIM_GUARD_W + 1)
`define DECIM_RATIO_W 4

`endif

// File: hw/dsp_types_pkg.sv
// Datapath types shared by the decimator stages and the testbench: samples, sums, errors, modes
`include "decim_settings.svh"

package dsp_types_pkg;

    // ------------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------------
    typedef logic signed [`DECIM_SAMPLE_W-1:0] sample_t;
    typedef logic signed [`DECIM_ACC_W-1:0] acc_t;

    // Difference between the sum and the rounded value
    typedef logic signed [`DECIM_ERR_W-1:0] err_t;

    // ------------------------------------------------------------------
    // IQ pairs, I in the upper half
    // ------------------------------------------------------------------
    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_sample_t;

    typedef struct packed {
        acc_t i;
        acc_t q;
    } iq_acc_t;

    typedef struct packed {
        err_t i;
        err_t q;
    } iq_err_t;

    // Code 3 is unassigned and rounds like truncate
    typedef enum logic [1:0] {
        RND_TRUNC   = 2'd0,
        RND_ZERO    = 2'd1,
        RND_NEAREST = 2'd2
    } round_mode_t;

endpackage

// File: hw/decim_ctrl_pkg.sv
// Controller types for the decimator: FSM state encoding and the latched configuration
`include "decim_settings.svh"

package decim_ctrl_pkg;

    import dsp_types_pkg::*;

    // ------------------------------------------------------------------
    // Controller states
    // ------------------------------------------------------------------
    // IDLE waits for enable, START flushes once, RUN accepts samples
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_START = 2'd1,
        ST_RUN   = 2'd2
    } ctrl_state_t;

    // ------------------------------------------------------------------
    // Configuration captured on enable
    // ------------------------------------------------------------------
    typedef struct packed {
        // Frame length minus one
        logic [`DECIM_RATIO_W-1:0] ratio_m1;
        round_mode_t               mode;
    } decim_cfg_t;

    // Value held after reset and before the first start
    localparam decim_cfg_t CFG_RESET = '{
        ratio_m1: '0,
        mode:     RND_TRUNC
    };

endpackage

// File: hw/decim_ctrl_fsm.sv
// Decimator controller: latches the configuration on enable and runs, flushes or stops the datapath
`timescale 1ns/10ps
`include "decim_settings.svh"

module decim_ctrl_fsm
    import dsp_types_pkg::*, decim_ctrl_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      enable_i,
    input  logic [`DECIM_RATIO_W-1:0] ratio_m1_i,
    input  round_mode_t               round_mode_i,
    output decim_cfg_t                cfg_o,
    output logic                      run_o,
    output logic                      flush_o
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        flush_q;
    decim_cfg_t  cfg_q;

    // ------------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (enable_i) begin
                    state_nxt = ST_START;
                end
            end
            ST_START: begin
                state_nxt = enable_i ? ST_RUN : ST_IDLE;
            end
            ST_RUN: begin
                if (!enable_i) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // State, flush pulse and configuration registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state   <= ST_IDLE;
            flush_q <= 1'b0;
            cfg_q   <= CFG_RESET;
        end else begin
            state <= state_nxt;
            // Flush for one cycle on start and on every return to idle
            flush_q <= (state_nxt == ST_START) ||
                       ((state != ST_IDLE) && (state_nxt == ST_IDLE));
            // Later changes on the inputs are ignored until the next start
            if (state == ST_IDLE && enable_i) begin
                cfg_q.ratio_m1 <= ratio_m1_i;
                cfg_q.mode     <= round_mode_i;
            end
        end
    end

    assign cfg_o   = cfg_q;
    assign run_o   = (state == ST_RUN);
    assign flush_o = flush_q;

endmodule

// File: hw/decim_phase_counter.sv
// Frame position counter: tracks accepted samples and marks the first and last of each frame
`timescale 1ns/10ps
`include "decim_settings.svh"

module decim_phase_counter (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      run_i,
    input  logic                      flush_i,
    input  logic                      sample_i,
    input  logic [`DECIM_RATIO_W-1:0] ratio_m1_i,
    output logic                      first_o,
    output logic                      last_o
);

    logic [`DECIM_RATIO_W-1:0] pos;
    logic                      at_end;

    assign at_end = (pos == ratio_m1_i);

    // ------------------------------------------------------------------
    // Position within the frame
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            pos <= '0;
        end else if (run_i && sample_i) begin
            // Wrap to zero after the last sample of the frame
            if (at_end) begin
                pos <= '0;
            end else begin
                pos <= pos + 1'b1;
            end
        end
    end

    // Held low while stopped so a stray strobe starts or ends nothing
    assign first_o = run_i && (pos == '0);
    assign last_o  = run_i && at_end;

endmodule

// File: hw/integrate_dump.sv
// Integrate-and-dump stage: sums each frame per channel and presents the completed sum for one cycle
`timescale 1ns/10ps
`include "decim_settings.svh"

module integrate_dump
    import dsp_types_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       run_i,
    input  logic       sample_i,
    input  iq_sample_t data_i,
    input  logic       first_i,
    input  logic       last_i,
    input  logic       flush_i,
    output iq_acc_t    sum_o,
    output logic       sum_valid_o
);

    sample_t [`DECIM_CH_NUM-1:0] smp;
    acc_t    [`DECIM_CH_NUM-1:0] sum_q;
    logic                        accept;

    // Channel array view, index 1 is I
    assign smp    = data_i;
    assign accept = sample_i && run_i;

    // ------------------------------------------------------------------
    // Per-channel accumulators
    // ------------------------------------------------------------------
    for (genvar c = 0; c < `DECIM_CH_NUM; c++) begin : g_ch
        acc_t ext;
        acc_t acc;
        acc_t acc_nxt;

        assign ext = acc_t'($signed(smp[c]));

        // The first sample restarts the frame
        assign acc_nxt = first_i ? ext : acc + ext;

        always_ff @(posedge clk_i) begin
            if (accept) begin
                acc <= acc_nxt;
            end
            // Dump includes the sample on this edge
            if (accept && last_i) begin
                sum_q[c] <= acc_nxt;
            end
        end
    end

    // ------------------------------------------------------------------
    // Dump strobe
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            sum_valid_o <= 1'b0;
        end else begin
            sum_valid_o <= accept && last_i;
        end
    end

    assign sum_o = sum_q;

endmodule

// File: hw/sample_round.sv
// Output rounding stage: reduces each channel sum to sample width and reports the rounding error
`timescale 1ns/10ps
`include "decim_settings.svh"

module sample_round
    import dsp_types_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  round_mode_t mode_i,
    input  iq_acc_t     sum_i,
    input  logic        sum_valid_i,
    output iq_sample_t  data_o,
    output iq_err_t     err_o,
    output logic        valid_o
);

    acc_t    [`DECIM_CH_NUM-1:0] sum_arr;
    sample_t [`DECIM_CH_NUM-1:0] rnd_data;
    err_t    [`DECIM_CH_NUM-1:0] rnd_err;

    assign sum_arr = sum_i;

    // ------------------------------------------------------------------
    // Per-channel rounding
    // ------------------------------------------------------------------
    for (genvar c = 0; c < `DECIM_CH_NUM; c++) begin : g_ch
        logic [`DECIM_SAMPLE_W-1:0] kept;
        logic [`DECIM_GUARD_W-1:0]  dropped;
        logic                       at_max;
        logic                       corr;
        acc_t                       diff;

        assign kept    = sum_arr[c][`DECIM_ACC_W-1:`DECIM_GUARD_W];
        assign dropped = sum_arr[c][`DECIM_GUARD_W-1:0];

        // Kept field already at positive full scale
        assign at_max = (kept == {1'b0, {(`DECIM_SAMPLE_W-1){1'b1}}});

        always_comb begin
            case (mode_i)
                RND_ZERO:    corr = kept[`DECIM_SAMPLE_W-1] && (|dropped);
                RND_NEAREST: corr = dropped[`DECIM_GUARD_W-1] && !at_max;
                default:     corr = 1'b0;
            endcase
        end

        assign rnd_data[c] = kept + {{(`DECIM_SAMPLE_W-1){1'b0}}, corr};

        // Error fits in guard width plus sign for every mode
        assign diff       = sum_arr[c] - {rnd_data[c], {`DECIM_GUARD_W{1'b0}}};
        assign rnd_err[c] = diff[`DECIM_ERR_W-1:0];
    end

    // ------------------------------------------------------------------
    // Output registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= sum_valid_i;
        end
        data_o <= rnd_data;
        err_o  <= rnd_err;
    end

endmodule

// File: hw/iq_decimator.sv
// Top level of the IQ integrate-and-dump decimator: controller, frame counter, accumulators, rounding
`timescale 1ns/10ps
`include "decim_settings.svh"

module iq_decimator
    import dsp_types_pkg::*, decim_ctrl_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      enable_i,
    input  logic [`DECIM_RATIO_W-1:0] ratio_m1_i,
    input  round_mode_t               round_mode_i,
    input  logic                      in_valid_i,
    input  iq_sample_t                in_data_i,
    output iq_sample_t                out_data_o,
    output iq_err_t                   out_err_o,
    output logic                      out_valid_o
);

    decim_cfg_t cfg;
    logic       run;
    logic       flush;
    logic       first;
    logic       last;
    iq_acc_t    sum;
    logic       sum_valid;

    // ------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------
    decim_ctrl_fsm decim_ctrl_fsm_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .enable_i     (enable_i),
        .ratio_m1_i   (ratio_m1_i),
        .round_mode_i (round_mode_i),
        .cfg_o        (cfg),
        .run_o        (run),
        .flush_o      (flush)
    );

    decim_phase_counter decim_phase_counter_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .run_i      (run),
        .flush_i    (flush),
        .sample_i   (in_valid_i),
        .ratio_m1_i (cfg.ratio_m1),
        .first_o    (first),
        .last_o     (last)
    );

    // ------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------
    integrate_dump integrate_dump_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .run_i       (run),
        .sample_i    (in_valid_i),
        .data_i      (in_data_i),
        .first_i     (first),
        .last_i      (last),
        .flush_i     (flush),
        .sum_o       (sum),
        .sum_valid_o (sum_valid)
    );

    sample_round sample_round_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .mode_i      (cfg.mode),
        .sum_i       (sum),
        .sum_valid_i (sum_valid),
        .data_o      (out_data_o),
        .err_o       (out_err_o),
        .valid_o     (out_valid_o)
    );

endmodule

// File: bench/iq_decimator_tb.sv
// Self-checking testbench that drives the IQ decimator and is run by the Makefile sim target
`timescale 1ns/10ps
`include "decim_settings.svh"

module iq_decimator_tb
    import dsp_types_pkg::*;
();

    localparam int MAX_CYCLES = 4000;
    localparam int MAX_RATIO  = 1 << `DECIM_RATIO_W;
    localparam int STEP       = 1 << `DECIM_GUARD_W;
    localparam int FULL_SCALE = (1 << (`DECIM_SAMPLE_W - 1)) - 1;

    typedef struct packed {
        sample_t val;
        err_t    err;
    } rounded_t;

    // One expected output and the cycle it must appear in
    typedef struct packed {
        iq_sample_t data;
        iq_err_t    err;
        int         cycle;
    } expect_t;

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic                      enable_i;
    logic [`DECIM_RATIO_W-1:0] ratio_m1_i;
    round_mode_t               round_mode_i;
    logic                      in_valid_i;
    iq_sample_t                in_data_i;
    iq_sample_t                out_data_o;
    iq_err_t                   out_err_o;
    logic                      out_valid_o;

    expect_t     exp_q[$];
    int          cycles = 0;
    logic [31:0] lcg_state;
    sample_t     frame_i [MAX_RATIO];
    sample_t     frame_q [MAX_RATIO];

    iq_decimator iq_decimator_inst (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .enable_i     (enable_i),
        .ratio_m1_i   (ratio_m1_i),
        .round_mode_i (round_mode_i),
        .in_valid_i   (in_valid_i),
        .in_data_i    (in_data_i),
        .out_data_o   (out_data_o),
        .out_err_o    (out_err_o),
        .out_valid_o  (out_valid_o)
    );

    initial begin
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic next_edge();
        @(posedge clk_i);
        #1;
    endtask

    // Reference rounding as floor of sum/16 plus the mode's correction
    function automatic rounded_t round_ref(input sample_t smp [MAX_RATIO], input int n,
                                           input round_mode_t mode);
        int       sum;
        int       floor_q;
        int       rem;
        int       rnd;
        rounded_t res;
        sum = 0;
        for (int k = 0; k < n; k++) begin
            sum += int'(smp[k]);
        end
        floor_q = sum >>> `DECIM_GUARD_W;
        rem     = sum - floor_q * STEP;
        rnd     = floor_q;
        if (mode == RND_ZERO && sum < 0 && rem != 0) begin
            rnd = floor_q + 1;
        end
        // No round up past positive full scale
        if (mode == RND_NEAREST && rem >= STEP / 2 && floor_q != FULL_SCALE) begin
            rnd = floor_q + 1;
        end
        res.val = sample_t'(rnd);
        res.err = err_t'(sum - rnd * STEP);
        return res;
    endfunction

    // Kind 0 random, 1 mostly negative, 2 random with full-scale frames
    function automatic sample_t make_sample(input int kind, input int frame);
        logic [31:0] r;
        sample_t     s;
        r = lcg_next();
        if (kind == 1) begin
            if (r[2:0] != 3'd0) begin
                r[31] = 1'b1;
            end
            // Whole steps of 16 so the frame rounds with no error
            if (frame % 3 == 0) begin
                r[19:16] = 4'd0;
            end
        end
        s = r[31:16];
        if (kind == 2 && frame % 3 == 0) begin
            s = {1'b0, {(`DECIM_SAMPLE_W-1){1'b1}}};
        end
        return s;
    endfunction

    // ------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------
    task automatic start_run(input logic [`DECIM_RATIO_W-1:0] ratio_m1, input round_mode_t mode);
        logic [31:0] r;
        ratio_m1_i   = ratio_m1;
        round_mode_i = mode;
        enable_i     = 1'b1;
        // Strobes in IDLE and START are ignored by the DUT
        in_valid_i   = 1'b1;
        in_data_i    = iq_sample_t'(lcg_next());
        next_edge();
        in_data_i    = iq_sample_t'(lcg_next());
        next_edge();
        in_valid_i   = 1'b0;
        // Config inputs now change without effect
        r            = lcg_next();
        ratio_m1_i   = r[`DECIM_RATIO_W+7:8];
        round_mode_i = round_mode_t'(r[1:0]);
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            next_edge();
        end
        next_edge();
    endtask

    task automatic stop_run();
        wait_drain();
        enable_i = 1'b0;
        next_edge();
        next_edge();
    endtask

    task automatic send_frames(input int ratio, input int frames, input int kind,
                               input int max_gap, input round_mode_t mode);
        logic [31:0] r;
        int          gap;
        expect_t     e;
        rounded_t    ri;
        rounded_t    rq;
        for (int f = 0; f < frames; f++) begin
            for (int k = 0; k < ratio; k++) begin
                r   = lcg_next();
                gap = int'(r[3:0]) % (max_gap + 1);
                in_valid_i = 1'b0;
                repeat (gap) next_edge();
                frame_i[k]  = make_sample(kind, f);
                frame_q[k]  = make_sample(kind, f);
                in_data_i.i = frame_i[k];
                in_data_i.q = frame_q[k];
                in_valid_i  = 1'b1;
                if (k == ratio - 1) begin
                    ri         = round_ref(frame_i, ratio, mode);
                    rq         = round_ref(frame_q, ratio, mode);
                    e.data.i   = ri.val;
                    e.data.q   = rq.val;
                    e.err.i    = ri.err;
                    e.err.q    = rq.err;
                    // Accepted on the next edge and registered out one edge later
                    e.cycle    = cycles + 2;
                    exp_q.push_back(e);
                end
                next_edge();
            end
        end
        in_valid_i = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Compare process and timeout
    // ------------------------------------------------------------------
    always @(negedge clk_i) begin
        expect_t e;
        if (out_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                abort_run("Output valid appeared with no completed frame outstanding");
            end else begin
                e = exp_q.pop_front();
                check_value("out_data_o.i", 32'(out_data_o.i), 32'(e.data.i));
                check_value("out_data_o.q", 32'(out_data_o.q), 32'(e.data.q));
                check_value("out_err_o.i", 32'(out_err_o.i), 32'(e.err.i));
                check_value("out_err_o.q", 32'(out_err_o.q), 32'(e.err.q));
                check_value("out_valid_o cycle", cycles, e.cycle);
            end
        end else if (out_valid_o !== 1'b0) begin
            abort_run("Output valid is unknown after reset");
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("Timeout: the run went past the cycle limit");
        end
    end

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------
    initial begin
        lcg_state    = 32'ha66c_2206;
        rst_i        = 1'b1;
        enable_i     = 1'b0;
        ratio_m1_i   = '0;
        round_mode_i = RND_TRUNC;
        in_valid_i   = 1'b0;
        in_data_i    = '0;
        repeat (2) next_edge();
        rst_i = 1'b0;
        repeat (3) next_edge();

        start_run(4'd15, RND_TRUNC);
        send_frames(16, 6, 0, 3, RND_TRUNC);
        stop_run();

        start_run(4'd4, RND_ZERO);
        send_frames(5, 9, 1, 2, RND_ZERO);
        stop_run();

        // Ratio 16 full-scale frames reach the top of the kept range
        start_run(4'd7, RND_NEAREST);
        send_frames(8, 9, 2, 2, RND_NEAREST);
        stop_run();
        start_run(4'd15, RND_NEAREST);
        send_frames(16, 3, 2, 1, RND_NEAREST);
        stop_run();

        start_run(4'd0, RND_TRUNC);
        send_frames(1, 40, 0, 0, RND_TRUNC);
        stop_run();

        // Partial frame then stop and restart with new settings
        start_run(4'd5, RND_TRUNC);
        for (int k = 0; k < 3; k++) begin
            in_data_i  = iq_sample_t'(lcg_next());
            in_valid_i = 1'b1;
            next_edge();
        end
        in_valid_i = 1'b0;
        enable_i   = 1'b0;
        repeat (4) next_edge();
        start_run(4'd2, RND_NEAREST);
        send_frames(3, 8, 0, 1, RND_NEAREST);
        stop_run();

        repeat (4) next_edge();
        if (exp_q.size() != 0) begin
            abort_run("Expected frames were never output");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: verilog.f
+incdir+hw
hw/dsp_types_pkg.sv
hw/decim_ctrl_pkg.sv
hw/decim_ctrl_fsm.sv
hw/decim_phase_counter.sv
hw/integrate_dump.sv
hw/sample_round.sv
hw/iq_decimator.sv
bench/iq_decimator_tb.sv

// File: Makefile
# Verilator build for the IQ decimator testbench

TOP = iq_decimator_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
